/* logic/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

`define PADDR_SIZE 32
`define XLEN 32
`define IRQ_NUM 2
`define PRIO_W 3

// Region bases and the offset width each slave sees
`define CLINT_BASE 32'h0200_0000
`define PLIC_BASE 32'h0C00_0000
`define UART_BASE 32'h1000_0000
`define CLINT_AW 16
`define PLIC_AW 22
`define UART_AW 16

`define CLINT_MSIP 16'h0000
`define CLINT_MTIMECMP_LO 16'h4000
`define CLINT_MTIMECMP_HI 16'h4004
`define CLINT_MTIME_LO 16'hBFF8
`define CLINT_MTIME_HI 16'hBFFC

// Priority of source n sits at 4*n from the PLIC base
`define PLIC_PENDING 22'h00_1000
`define PLIC_ENABLE 22'h00_2000
`define PLIC_THRESHOLD 22'h20_0000
`define PLIC_CLAIM 22'h20_0004

`define UART_DATA 16'h0000
`define UART_STATUS 16'h0004
`define UART_CTRL 16'h0008
`define UART_DIV 16'h000C
`define UART_DIV_RST 16

`endif

/* logic/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    typedef enum logic [1:0] {
        SEL_CLINT,
        SEL_PLIC,
        SEL_UART,
        SEL_NONE
    } bus_sel_t;

    // Frame phase, shared by transmitter and receiver
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_t;

    // 0 is no interrupt, 1 the UART, 2 the external line
    typedef logic [1:0] irq_id_t;

endpackage

`default_nettype wire

/* logic/apb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module apb_decoder
    import soc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic [`PADDR_SIZE-1:0] paddr_i,
    input  logic [`XLEN-1:0]       clint_rdata_i,
    input  logic [`XLEN-1:0]       plic_rdata_i,
    input  logic [`XLEN-1:0]       uart_rdata_i,
    output logic                   clint_sel_o,
    output logic                   plic_sel_o,
    output logic                   uart_sel_o,
    output logic [`XLEN-1:0]       prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);
    bus_sel_t sel;
    bus_sel_t sel_q;

    function automatic logic in_region(input logic [`PADDR_SIZE-1:0] addr,
                                       input logic [`PADDR_SIZE-1:0] base,
                                       input int unsigned            aw);
        return (addr >> aw) == (base >> aw);
    endfunction

    always_comb begin
        if (in_region(paddr_i, `CLINT_BASE, `CLINT_AW)) begin
            sel = SEL_CLINT;
        end else if (in_region(paddr_i, `PLIC_BASE, `PLIC_AW)) begin
            sel = SEL_PLIC;
        end else if (in_region(paddr_i, `UART_BASE, `UART_AW)) begin
            sel = SEL_UART;
        end else begin
            sel = SEL_NONE;
        end
    end

    // Slave choice is taken in the setup phase and held for the access phase
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sel_q <= SEL_NONE;
        end else if (psel_i && !penable_i) begin
            sel_q <= sel;
        end
    end

    assign clint_sel_o = psel_i && (sel == SEL_CLINT);
    assign plic_sel_o  = psel_i && (sel == SEL_PLIC);
    assign uart_sel_o  = psel_i && (sel == SEL_UART);

    always_comb begin
        case (sel_q)
            SEL_CLINT: prdata_o = clint_rdata_i;
            SEL_PLIC:  prdata_o = plic_rdata_i;
            SEL_UART:  prdata_o = uart_rdata_i;
            default:   prdata_o = '0;
        endcase
    end

    // Zero wait states on every slave
    assign pready_o  = psel_i && penable_i;
    assign pslverr_o = psel_i && penable_i && (sel_q == SEL_NONE);

endmodule

`default_nettype wire

/* logic/clint.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module clint (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 sel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  logic [`CLINT_AW-1:0] addr_i,
    input  logic [`XLEN-1:0]     wdata_i,
    input  logic                 rtc_clk_i,
    output logic [`XLEN-1:0]     rdata_o,
    output logic                 msip_o,
    output logic                 mtip_o
);
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic [2:0]  rtc_sync_q;
    logic        wr_en;
    logic        rtc_tick;

    assign wr_en = sel_i && penable_i && pwrite_i;

    // Two flops into the clk domain, the third one finds the rising edge
    assign rtc_tick = rtc_sync_q[1] && !rtc_sync_q[2];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rtc_sync_q <= '0;
            msip_o     <= 1'b0;
            mtip_o     <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
        end else begin
            rtc_sync_q <= {rtc_sync_q[1:0], rtc_clk_i};
            if (wr_en) begin
                case (addr_i)
                    `CLINT_MSIP:        msip_o <= wdata_i[0];
                    `CLINT_MTIMECMP_LO: mtimecmp_q[31:0] <= wdata_i;
                    `CLINT_MTIMECMP_HI: mtimecmp_q[63:32] <= wdata_i;
                    default:            ;
                endcase
            end
            // A software write to mtime takes precedence over the tick
            if (wr_en && addr_i == `CLINT_MTIME_LO) begin
                mtime_q[31:0] <= wdata_i;
            end else if (wr_en && addr_i == `CLINT_MTIME_HI) begin
                mtime_q[63:32] <= wdata_i;
            end else if (rtc_tick) begin
                mtime_q <= mtime_q + 64'd1;
            end
            mtip_o <= (mtime_q >= mtimecmp_q);
        end
    end

    always_comb begin
        case (addr_i)
            `CLINT_MSIP:        rdata_o = {{(`XLEN-1){1'b0}}, msip_o};
            `CLINT_MTIMECMP_LO: rdata_o = mtimecmp_q[31:0];
            `CLINT_MTIMECMP_HI: rdata_o = mtimecmp_q[63:32];
            `CLINT_MTIME_LO:    rdata_o = mtime_q[31:0];
            `CLINT_MTIME_HI:    rdata_o = mtime_q[63:32];
            default:            rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/plic.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module plic
    import soc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                sel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  logic [`PLIC_AW-1:0] addr_i,
    input  logic [`XLEN-1:0]    wdata_i,
    input  logic [`IRQ_NUM-1:0] irq_src_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic                meip_o
);
    logic [`PRIO_W-1:0] prio_q [1:`IRQ_NUM];
    logic [`IRQ_NUM:1]  pend_q;
    logic [`IRQ_NUM:1]  en_q;
    logic [`IRQ_NUM:1]  claimed_q;
    logic [`PRIO_W-1:0] thresh_q;
    logic [`PRIO_W-1:0] best_prio;
    irq_id_t            best_id;
    irq_id_t            complete_id;
    logic               wr_en;
    logic               claim_rd;
    logic               complete_wr;

    assign wr_en       = sel_i && penable_i && pwrite_i;
    assign claim_rd    = sel_i && penable_i && !pwrite_i && (addr_i == `PLIC_CLAIM);
    assign complete_wr = wr_en && (addr_i == `PLIC_CLAIM);
    assign complete_id = wdata_i[$bits(irq_id_t)-1:0];

    // Strict compare keeps the lower id on a tie and enforces the threshold
    always_comb begin
        best_id   = '0;
        best_prio = thresh_q;
        for (int n = 1; n <= `IRQ_NUM; n++) begin
            if (pend_q[n] && en_q[n] && prio_q[n] > best_prio) begin
                best_id   = irq_id_t'(n);
                best_prio = prio_q[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int n = 1; n <= `IRQ_NUM; n++) begin
                prio_q[n] <= '0;
            end
            pend_q    <= '0;
            en_q      <= '0;
            claimed_q <= '0;
            thresh_q  <= '0;
            meip_o    <= 1'b0;
        end else begin
            for (int n = 1; n <= `IRQ_NUM; n++) begin
                // Level gateway, masked from claim until complete
                if (irq_src_i[n-1] && !claimed_q[n]) begin
                    pend_q[n] <= 1'b1;
                end
                if (claim_rd && best_id == irq_id_t'(n)) begin
                    pend_q[n]    <= 1'b0;
                    claimed_q[n] <= 1'b1;
                end
                if (complete_wr && complete_id == irq_id_t'(n)) begin
                    claimed_q[n] <= 1'b0;
                end
                if (wr_en && addr_i == `PLIC_AW'(4 * n)) begin
                    prio_q[n] <= wdata_i[`PRIO_W-1:0];
                end
            end
            if (wr_en && addr_i == `PLIC_ENABLE) begin
                en_q <= wdata_i[`IRQ_NUM:1];
            end
            if (wr_en && addr_i == `PLIC_THRESHOLD) begin
                thresh_q <= wdata_i[`PRIO_W-1:0];
            end
            meip_o <= (best_id != '0);
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int n = 1; n <= `IRQ_NUM; n++) begin
            if (addr_i == `PLIC_AW'(4 * n)) begin
                rdata_o = `XLEN'(prio_q[n]);
            end
        end
        case (addr_i)
            `PLIC_PENDING:   rdata_o = `XLEN'({pend_q, 1'b0});
            `PLIC_ENABLE:    rdata_o = `XLEN'({en_q, 1'b0});
            `PLIC_THRESHOLD: rdata_o = `XLEN'(thresh_q);
            `PLIC_CLAIM:     rdata_o = `XLEN'(best_id);
            default:         ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/uart.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module uart
    import soc_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                sel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  logic [`UART_AW-1:0] addr_i,
    input  logic [`XLEN-1:0]    wdata_i,
    input  logic                rxd_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic                txd_o,
    output logic                irq_o
);
    localparam int DIV_W = 16;

    uart_state_t      tx_state;
    uart_state_t      rx_state;
    logic [DIV_W-1:0] div_q;
    logic [DIV_W-1:0] half_bit;
    logic [DIV_W-1:0] tx_baud;
    logic [DIV_W-1:0] rx_baud;
    logic [2:0]       tx_bit;
    logic [2:0]       rx_bit;
    logic [7:0]       tx_shift;
    logic [7:0]       rx_shift;
    logic [7:0]       rx_data;
    logic [1:0]       rxd_sync;
    logic             rxd_s;
    logic             rx_valid;
    logic             ctrl_q;
    logic             tx_busy;
    logic             wr_en;
    logic             rd_data;

    assign wr_en   = sel_i && penable_i && pwrite_i;
    assign rd_data = sel_i && penable_i && !pwrite_i && (addr_i == `UART_DATA);
    assign tx_busy = (tx_state != IDLE);
    assign irq_o   = rx_valid && ctrl_q;
    assign rxd_s   = rxd_sync[1];

    // Delay from the start edge to the middle of the start bit
    assign half_bit = (div_q > DIV_W'(1)) ? (div_q >> 1) - DIV_W'(1) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            div_q  <= DIV_W'(`UART_DIV_RST);
            ctrl_q <= 1'b0;
        end else if (wr_en) begin
            case (addr_i)
                `UART_CTRL: ctrl_q <= wdata_i[0];
                `UART_DIV:  div_q <= wdata_i[DIV_W-1:0];
                default:    ;
            endcase
        end
    end

    // Line is low in the start bit, LSB first in data, high otherwise
    assign txd_o = (tx_state == START) ? 1'b0 : (tx_state == DATA) ? tx_shift[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tx_state <= IDLE;
            tx_baud  <= '0;
            tx_bit   <= '0;
            tx_shift <= '0;
        end else if (tx_state == IDLE) begin
            // Writes while busy never reach this branch and are dropped
            if (wr_en && addr_i == `UART_DATA) begin
                tx_shift <= wdata_i[7:0];
                tx_baud  <= div_q - DIV_W'(1);
                tx_state <= START;
            end
        end else if (tx_baud != '0) begin
            tx_baud <= tx_baud - DIV_W'(1);
        end else begin
            tx_baud <= div_q - DIV_W'(1);
            case (tx_state)
                START: begin
                    tx_bit   <= '0;
                    tx_state <= DATA;
                end
                DATA: begin
                    tx_bit   <= tx_bit + 3'd1;
                    tx_shift <= tx_shift >> 1;
                    if (tx_bit == 3'd7) begin
                        tx_state <= STOP;
                    end
                end
                default: tx_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rxd_sync <= 2'b11;
            rx_state <= IDLE;
            rx_baud  <= '0;
            rx_bit   <= '0;
            rx_shift <= '0;
            rx_data  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd_i};
            if (rd_data) begin
                rx_valid <= 1'b0;
            end
            if (rx_state != IDLE && rx_baud != '0) begin
                rx_baud <= rx_baud - DIV_W'(1);
            end else begin
                rx_baud <= div_q - DIV_W'(1);
                case (rx_state)
                    IDLE: begin
                        rx_baud <= half_bit;
                        if (!rxd_s) begin
                            rx_state <= START;
                        end
                    end
                    START: begin
                        // A start bit gone high by mid-bit was a glitch
                        rx_bit   <= '0;
                        rx_state <= rxd_s ? IDLE : DATA;
                    end
                    DATA: begin
                        rx_shift <= {rxd_s, rx_shift[7:1]};
                        rx_bit   <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= STOP;
                        end
                    end
                    default: begin
                        if (rxd_s) begin
                            rx_data  <= rx_shift;
                            rx_valid <= 1'b1;
                        end
                        rx_state <= IDLE;
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (addr_i)
            `UART_DATA:   rdata_o = `XLEN'(rx_data);
            `UART_STATUS: rdata_o = `XLEN'({rx_valid, tx_busy});
            `UART_CTRL:   rdata_o = `XLEN'(ctrl_q);
            `UART_DIV:    rdata_o = `XLEN'(div_q);
            default:      rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module soc_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   rtc_clk_i,
    input  logic                   rxd_i,
    input  logic                   ext_irq_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`PADDR_SIZE-1:0] paddr_i,
    input  logic [`XLEN-1:0]       pwdata_i,
    output logic [`XLEN-1:0]       prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output logic                   txd_o,
    output logic                   meip_o,
    output logic                   mtip_o,
    output logic                   msip_o
);
    logic [2:0]          rst_stage;
    logic                sys_rst_n;
    logic                clint_sel;
    logic                plic_sel;
    logic                uart_sel;
    logic [`XLEN-1:0]    clint_rdata;
    logic [`XLEN-1:0]    plic_rdata;
    logic [`XLEN-1:0]    uart_rdata;
    logic                uart_irq;
    logic [`IRQ_NUM-1:0] irq_src;

    // All blocks leave reset three clocks after rst_n_i rises
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rst_stage <= '0;
        end else begin
            rst_stage <= {rst_stage[1:0], 1'b1};
        end
    end
    assign sys_rst_n = rst_stage[2];

    // Source 1 is the UART, source 2 the external line
    assign irq_src = {ext_irq_i, uart_irq};

    apb_decoder u_decoder (
        .clk           (clk),
        .rst_n_i       (sys_rst_n),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .paddr_i       (paddr_i),
        .clint_rdata_i (clint_rdata),
        .plic_rdata_i  (plic_rdata),
        .uart_rdata_i  (uart_rdata),
        .clint_sel_o   (clint_sel),
        .plic_sel_o    (plic_sel),
        .uart_sel_o    (uart_sel),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o)
    );

    clint u_clint (
        .clk       (clk),
        .rst_n_i   (sys_rst_n),
        .sel_i     (clint_sel),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .addr_i    (paddr_i[`CLINT_AW-1:0]),
        .wdata_i   (pwdata_i),
        .rtc_clk_i (rtc_clk_i),
        .rdata_o   (clint_rdata),
        .msip_o    (msip_o),
        .mtip_o    (mtip_o)
    );

    plic u_plic (
        .clk       (clk),
        .rst_n_i   (sys_rst_n),
        .sel_i     (plic_sel),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .addr_i    (paddr_i[`PLIC_AW-1:0]),
        .wdata_i   (pwdata_i),
        .irq_src_i (irq_src),
        .rdata_o   (plic_rdata),
        .meip_o    (meip_o)
    );

    uart u_uart (
        .clk       (clk),
        .rst_n_i   (sys_rst_n),
        .sel_i     (uart_sel),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .addr_i    (paddr_i[`UART_AW-1:0]),
        .wdata_i   (pwdata_i),
        .rxd_i     (rxd_i),
        .rdata_o   (uart_rdata),
        .txd_o     (txd_o),
        .irq_o     (uart_irq)
    );

endmodule

`default_nettype wire

/* test/soc_sva.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module soc_sva
    import soc_pkg::*;
(
    input logic              clk,
    input logic              rst_n_i,
    input logic              psel_i,
    input logic              penable_i,
    input logic              pready_i,
    input logic              pslverr_i,
    input bus_sel_t          dec_sel_i,
    input uart_state_t       tx_state_i,
    input logic              txd_i,
    input logic [`IRQ_NUM:1] plic_en_i,
    input logic              meip_i
);
    int unsigned violations = 0;

    // Every access phase follows a setup phase and completes at once
    a_pready: assert property (@(posedge clk) disable iff (!rst_n_i)
        psel_i && penable_i |-> pready_i && $past(psel_i && !penable_i))
        else begin
            violations++;
            $error("pready low in an APB access phase or access without setup");
        end

    a_pslverr: assert property (@(posedge clk) disable iff (!rst_n_i)
        pslverr_i |-> dec_sel_i == SEL_NONE)
        else begin
            violations++;
            $error("pslverr high for a mapped slave");
        end

    // Line idles high between frames
    a_txd_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_state_i == IDLE |-> txd_i)
        else begin
            violations++;
            $error("txd low while the transmitter is idle");
        end

    a_meip_enable: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(meip_i) |-> $past(plic_en_i) != '0)
        else begin
            violations++;
            $error("meip rose with every PLIC enable bit clear");
        end

endmodule

`default_nettype wire

/* test/soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_cfg.svh"

module soc_tb
    import soc_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int FRAME_POLLS    = 40;

    localparam logic [31:0] MSIP_ADDR        = `CLINT_BASE + 32'(`CLINT_MSIP);
    localparam logic [31:0] MTIMECMP_LO_ADDR = `CLINT_BASE + 32'(`CLINT_MTIMECMP_LO);
    localparam logic [31:0] MTIMECMP_HI_ADDR = `CLINT_BASE + 32'(`CLINT_MTIMECMP_HI);
    localparam logic [31:0] MTIME_LO_ADDR    = `CLINT_BASE + 32'(`CLINT_MTIME_LO);
    localparam logic [31:0] PRIO1_ADDR       = `PLIC_BASE + 32'd4;
    localparam logic [31:0] PRIO2_ADDR       = `PLIC_BASE + 32'd8;
    localparam logic [31:0] PENDING_ADDR     = `PLIC_BASE + 32'(`PLIC_PENDING);
    localparam logic [31:0] ENABLE_ADDR      = `PLIC_BASE + 32'(`PLIC_ENABLE);
    localparam logic [31:0] THRESH_ADDR      = `PLIC_BASE + 32'(`PLIC_THRESHOLD);
    localparam logic [31:0] CLAIM_ADDR       = `PLIC_BASE + 32'(`PLIC_CLAIM);
    localparam logic [31:0] UART_DATA_ADDR   = `UART_BASE + 32'(`UART_DATA);
    localparam logic [31:0] UART_STATUS_ADDR = `UART_BASE + 32'(`UART_STATUS);
    localparam logic [31:0] UART_CTRL_ADDR   = `UART_BASE + 32'(`UART_CTRL);
    localparam logic [31:0] UART_DIV_ADDR    = `UART_BASE + 32'(`UART_DIV);
    localparam logic [31:0] UNMAPPED_ADDR    = 32'h3000_0000;

    localparam irq_id_t ID_UART = irq_id_t'(1);
    localparam irq_id_t ID_EXT  = irq_id_t'(2);

    logic        clk;
    logic        rst_n_i;
    logic        rtc_clk_i;
    logic        ext_irq_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [31:0] paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic        txd_o;
    logic        meip_o;
    logic        mtip_o;
    logic        msip_o;
    logic [15:0] lfsr_state = 16'd18;
    int          cycle_count = 0;

    // Serial line looped back from txd_o to rxd_i
    soc_top dut (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rtc_clk_i (rtc_clk_i),
        .rxd_i     (txd_o),
        .ext_irq_i (ext_irq_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .txd_o     (txd_o),
        .meip_o    (meip_o),
        .mtip_o    (mtip_o),
        .msip_o    (msip_o)
    );

    bind soc_top soc_sva u_sva (
        .clk        (clk),
        .rst_n_i    (sys_rst_n),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pready_i   (pready_o),
        .pslverr_i  (pslverr_o),
        .dec_sel_i  (u_decoder.sel),
        .tx_state_i (u_uart.tx_state),
        .txd_i      (txd_o),
        .plic_en_i  (u_plic.en_q),
        .meip_i     (meip_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // rtc runs at one sixteenth of clk
    initial begin
        rtc_clk_i <= 1'b0;
        forever begin
            repeat (8) @(posedge clk);
            rtc_clk_i <= ~rtc_clk_i;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the run did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    always @(negedge clk) begin
        if (dut.u_sva.violations != 0) begin
            abort_run("A bus or interrupt assertion failed in the bound checker");
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("CHECK FAILED at %0t ns: %s read %h, expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_true(input string what, input bit cond);
        assert (cond) else
            abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        rdata = prdata_o;
        err   = pslverr_o;
        check_true("pready_o high in the access phase", pready_o === 1'b1);
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused_rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, unused_rdata, err);
        check_true($sformatf("write to %h without pslverr", addr), err === 1'b0);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        logic err;
        apb_transfer(1'b0, addr, 32'h0, data, err);
        check_true($sformatf("read of %h without pslverr", addr), err === 1'b0);
    endtask

    task automatic wait_for_irq(input bit use_mtip, input logic level, input int limit,
                                input string what);
        int waited;
        bit seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < limit) begin
            @(negedge clk);
            seen = ((use_mtip ? mtip_o : meip_o) === level);
            waited++;
        end
        check_true($sformatf("%s within %0d cycles", what, limit), seen);
    endtask

    task automatic send_byte(input logic [7:0] value);
        logic [31:0] status;
        int          polls;
        apb_write(UART_DATA_ADDR, 32'(value));
        apb_read(UART_STATUS_ADDR, status);
        check_true("tx_busy right after a data write", status[0] === 1'b1);
        polls = 0;
        while (status[1] !== 1'b1 && polls < FRAME_POLLS) begin
            apb_read(UART_STATUS_ADDR, status);
            polls++;
        end
        check_true("rx_valid after a looped back frame", status[1] === 1'b1);
        // Depending on the divisor the stop bit may still be going out
        polls = 0;
        while (status[0] !== 1'b0 && polls < FRAME_POLLS) begin
            apb_read(UART_STATUS_ADDR, status);
            polls++;
        end
        check_true("tx_busy clears at the end of the frame", status[0] === 1'b0);
    endtask

    task automatic test_registers();
        logic [31:0] cmp_lo;
        logic [31:0] cmp_hi;
        logic [31:0] rdata;
        logic        err;
        apb_write(UART_DIV_ADDR, 32'd4);
        apb_read(UART_DIV_ADDR, rdata);
        check_value("UART divisor", rdata, 32'd4);
        apb_write(PRIO1_ADDR, 32'd3);
        apb_write(PRIO2_ADDR, 32'd5);
        apb_write(THRESH_ADDR, 32'd2);
        apb_read(PRIO1_ADDR, rdata);
        check_value("PLIC priority 1", rdata, 32'd3);
        apb_read(PRIO2_ADDR, rdata);
        check_value("PLIC priority 2", rdata, 32'd5);
        apb_read(THRESH_ADDR, rdata);
        check_value("PLIC threshold", rdata, 32'd2);
        draw_bits(32, cmp_lo);
        draw_bits(32, cmp_hi);
        apb_write(MTIMECMP_LO_ADDR, cmp_lo);
        apb_write(MTIMECMP_HI_ADDR, cmp_hi);
        apb_read(MTIMECMP_LO_ADDR, rdata);
        check_value("mtimecmp low", rdata, cmp_lo);
        apb_read(MTIMECMP_HI_ADDR, rdata);
        check_value("mtimecmp high", rdata, cmp_hi);
        apb_transfer(1'b0, UNMAPPED_ADDR, 32'h0, rdata, err);
        check_true("pslverr on an unmapped read", err === 1'b1);
        check_value("unmapped read data", rdata, 32'h0);
        apb_transfer(1'b1, UNMAPPED_ADDR, 32'hA5A5_A5A5, rdata, err);
        check_true("pslverr on an unmapped write", err === 1'b1);
    endtask

    task automatic test_clint();
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] step;
        apb_write(MSIP_ADDR, 32'd1);
        @(negedge clk);
        check_true("msip_o high after writing 1", msip_o === 1'b1);
        apb_write(MSIP_ADDR, 32'd0);
        @(negedge clk);
        check_true("msip_o low after writing 0", msip_o === 1'b0);
        apb_read(MTIME_LO_ADDR, t0);
        repeat (48) @(posedge clk);
        apb_read(MTIME_LO_ADDR, t1);
        check_true("mtime advanced over three rtc periods", t1 > t0);
        apb_write(MTIMECMP_LO_ADDR, 32'hFFFF_FFFF);
        apb_write(MTIMECMP_HI_ADDR, 32'h0);
        apb_read(MTIME_LO_ADDR, t0);
        draw_bits(2, step);
        apb_write(MTIMECMP_LO_ADDR, t0 + 32'd4 + step);
        @(negedge clk);
        check_true("mtip_o low before mtime reaches mtimecmp", mtip_o === 1'b0);
        wait_for_irq(1'b1, 1'b1, 200, "mtip_o rising");
    endtask

    task automatic test_uart_loopback();
        logic [31:0] value;
        logic [31:0] rdata;
        for (int i = 0; i < 8; i++) begin
            draw_bits(8, value);
            send_byte(value[7:0]);
            apb_read(UART_DATA_ADDR, rdata);
            check_value("looped back byte", rdata, 32'(value[7:0]));
            apb_read(UART_STATUS_ADDR, rdata);
            check_true("rx_valid cleared by the data read", rdata[1] === 1'b0);
        end
    endtask

    task automatic test_plic();
        logic [31:0] value;
        logic [31:0] rdata;
        apb_write(ENABLE_ADDR, 32'h4);
        apb_read(ENABLE_ADDR, rdata);
        check_value("PLIC enable", rdata, 32'h4);
        @(posedge clk);
        ext_irq_i <= 1'b1;
        wait_for_irq(1'b0, 1'b1, 10, "meip_o on source 2");
        apb_write(THRESH_ADDR, 32'd5);
        repeat (3) @(negedge clk);
        check_true("meip_o low with the threshold at the priority", meip_o === 1'b0);
        apb_write(THRESH_ADDR, 32'd2);
        wait_for_irq(1'b0, 1'b1, 10, "meip_o after the threshold drops");
        // With equal priorities the lower id wins the claim
        apb_write(PRIO2_ADDR, 32'd3);
        apb_write(UART_CTRL_ADDR, 32'd1);
        draw_bits(8, value);
        send_byte(value[7:0]);
        apb_write(ENABLE_ADDR, 32'h6);
        apb_read(PENDING_ADDR, rdata);
        check_value("both sources pending", rdata, 32'h6);
        apb_read(CLAIM_ADDR, rdata);
        check_value("first claim", rdata, 32'(ID_UART));
        apb_read(CLAIM_ADDR, rdata);
        check_value("second claim", rdata, 32'(ID_EXT));
        @(posedge clk);
        ext_irq_i <= 1'b0;
        apb_read(UART_DATA_ADDR, rdata);
        check_value("UART byte behind the interrupt", rdata, 32'(value[7:0]));
        apb_write(CLAIM_ADDR, 32'(ID_UART));
        apb_write(CLAIM_ADDR, 32'(ID_EXT));
        repeat (3) @(negedge clk);
        check_true("meip_o low after both completes", meip_o === 1'b0);
    endtask

    task automatic test_uart_irq();
        logic [31:0] value;
        logic [31:0] rdata;
        apb_write(ENABLE_ADDR, 32'h2);
        draw_bits(8, value);
        send_byte(value[7:0]);
        wait_for_irq(1'b0, 1'b1, 10, "meip_o on the UART interrupt");
        apb_read(CLAIM_ADDR, rdata);
        check_value("UART claim", rdata, 32'(ID_UART));
        apb_read(UART_DATA_ADDR, rdata);
        check_value("UART byte after claim", rdata, 32'(value[7:0]));
        apb_write(CLAIM_ADDR, 32'(ID_UART));
        repeat (3) @(negedge clk);
        check_true("meip_o low after the UART complete", meip_o === 1'b0);
        apb_write(UART_CTRL_ADDR, 32'd0);
    endtask

    initial begin
        rst_n_i   <= 1'b0;
        ext_irq_i <= 1'b0;
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
        paddr_i   <= 32'h0;
        pwdata_i  <= 32'h0;
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        // Internal reset stage adds three cycles
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_true("txd_o idle high after reset", txd_o === 1'b1);
        check_true("interrupt lines low after reset",
                   meip_o === 1'b0 && mtip_o === 1'b0 && msip_o === 1'b0);
        check_true("pslverr_o low after reset", pslverr_o === 1'b0);
        test_registers();
        test_clint();
        test_uart_loopback();
        test_plic();
        test_uart_irq();
        repeat (5) @(posedge clk);
        if (dut.u_sva.violations != 0) begin
            abort_run("Assertion failures were recorded during the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* soc_sys.f */
+incdir+logic
logic/soc_pkg.sv
logic/apb_decoder.sv
logic/clint.sv
logic/plic.sv
logic/uart.sv
logic/soc_top.sv
test/soc_sva.sv
test/soc_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_tb -f soc_sys.f -o soc_sim

output=$(./obj_dir/soc_sim +verilator+error+limit+10 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
